// File: tb.f
+incdir+verilog
verilog/ccu_pkg.sv
verilog/req_intake.sv
verilog/snoop_issue_fsm.sv
verilog/pending_fifo.sv
verilog/resp_collector.sv
verilog/ccu_snoop_ctrl.sv
testbench/ccu_snoop_ctrl_asserts.sv
testbench/tb_ccu_snoop_ctrl.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f \
    --top-module tb_ccu_snoop_ctrl -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

// File: testbench/tb_ccu_snoop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_defs.svh"

module tb_ccu_snoop_ctrl import ccu_pkg::*; ();

    typedef struct packed {
        logic        is_w;
        logic [1:0]  init;
        snoop_e      snoop;
        logic [15:0] cr;
        snoop_e      exp_ac;
        logic        exp_su;
        mu_op_e      exp_op;
        logic        exp_sh;
        logic        exp_dt;
        logic [1:0]  exp_first;
    } row_t;

    logic clk_i, rst_ni, aw_valid, ar_valid, su_gnt, mu_gnt, hold_gnt;
    axi_req_t aw, ar, pend;
    snoop_ac_t ac;
    wire [`CCU_NUM_MST-1:0] ac_valid, ac_ready, cr_valid, cr_ready;
    wire cr_resp_t [`CCU_NUM_MST-1:0] cr_resp;
    wire aw_ready, ar_ready, su_req, mu_req, shared, dirty;
    wire [`CCU_MST_IDX_W-1:0] first;
    mu_op_e mu_op;
    row_t tbl [8];
    int errors, disp_cnt;

    ccu_snoop_ctrl ccu_snoop_ctrl_i (
        .clk_i, .rst_ni, .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ac_o(ac),
        .ac_valid_o(ac_valid), .ac_ready_i(ac_ready), .cr_valid_i(cr_valid),
        .cr_ready_o(cr_ready), .cr_resp_i(cr_resp), .su_req_o(su_req), .su_gnt_i(su_gnt),
        .mu_req_o(mu_req), .mu_gnt_i(mu_gnt), .mu_op_o(mu_op), .pend_o(pend),
        .shared_o(shared), .dirty_o(dirty), .first_responder_o(first)
    );

    bind ccu_snoop_ctrl ccu_snoop_ctrl_asserts asserts_i (
        .clk_i, .rst_ni, .take_i(take), .offer_i(offer), .ac_o, .ac_valid_o, .ac_ready_i,
        .su_req_o, .su_gnt_i, .mu_req_o, .mu_gnt_i
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] row_addr(input int pass, input int i);
        return 32'h8000_0000 | (pass << 12) | (i << 6);
    endfunction

    // --------------------
    // Master models
    // --------------------
    for (genvar m = 0; m < `CCU_NUM_MST; m++) begin : g_mst
        logic ac_rdy, cr_vld;
        cr_resp_t cr_val;
        int rows_q [$];
        assign ac_ready[m] = ac_rdy;
        assign cr_valid[m] = cr_vld;
        assign cr_resp[m]  = cr_val;

        initial begin
            int r, k;
            ac_rdy = 1'b0;
            k = 0;
            forever begin
                @(negedge clk_i);
                if (ac_valid[m]) begin
                    // Next row in table order that this master did not issue
                    while (tbl[k % 8].init == m) begin
                        k++;
                    end
                    r = k % 8;
                    check($sformatf("row%0d ac addr", r), row_addr(k / 8, r), ac.addr);
                    check($sformatf("row%0d ac snoop", r), tbl[r].exp_ac, ac.snoop);
                    k++;
                    repeat ($urandom_range(0, 3)) @(posedge clk_i);
                    @(posedge clk_i);
                    #2 ac_rdy = 1'b1;
                    rows_q.push_back(r);
                    @(posedge clk_i);
                    #2 ac_rdy = 1'b0;
                end
            end
        end

        initial begin
            int r, t;
            cr_vld = 1'b0;
            cr_val = '0;
            forever begin
                @(negedge clk_i);
                if (rows_q.size() != 0) begin
                    r = rows_q[0];
                    repeat ($urandom_range(0, 3)) @(posedge clk_i);
                    @(posedge clk_i);
                    #2 cr_vld = 1'b1;
                    cr_val = cr_resp_t'(tbl[r].cr[4*m +: 4]);
                    t = 0;
                    do begin
                        @(negedge clk_i);
                        t++;
                    end while (!cr_ready[m] && t < 2000);
                    if (t >= 2000) begin
                        errors++;
                        $display("Master %0d timed out waiting for CR ready", m);
                    end
                    @(posedge clk_i);
                    #2 cr_vld = 1'b0;
                    void'(rows_q.pop_front());
                end
            end
        end
    end

    initial begin
        su_gnt = 1'b0;
        mu_gnt = 1'b0;
        forever begin
            @(posedge clk_i);
            #2;
            su_gnt = !hold_gnt && ($urandom_range(0, 2) == 0);
            mu_gnt = !hold_gnt && ($urandom_range(0, 2) == 0);
        end
    end

    // --------------------
    // Dispatch monitor
    // --------------------
    task automatic check_dispatch();
        int r;
        string n;
        r = disp_cnt % 8;
        n = $sformatf("row%0d", r);
        check({n, " addr"}, row_addr(disp_cnt / 8, r), pend.addr);
        check({n, " mst_idx"}, tbl[r].init, pend.mst_idx);
        check({n, " tag"}, r, pend.tag);
        check({n, " snoop"}, tbl[r].snoop, pend.snoop);
        check({n, " su_req"}, tbl[r].exp_su, su_req);
        if (tbl[r].exp_su) begin
            check({n, " first"}, tbl[r].exp_first, first);
        end else begin
            check({n, " mu_op"}, tbl[r].exp_op, mu_op);
        end
        check({n, " shared"}, tbl[r].exp_sh, shared);
        check({n, " dirty"}, tbl[r].exp_dt, dirty);
        disp_cnt++;
    endtask

    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                if ((su_req && su_gnt) || (mu_req && mu_gnt)) begin
                    check_dispatch();
                end
            end
        end
    end

    // One channel sends its rows in table order
    task automatic drive_channel(input logic is_w, input int pass);
        axi_req_t req;
        int t;
        for (int i = 0; i < 8; i++) begin
            if (tbl[i].is_w == is_w) begin
                req = '{addr: row_addr(pass, i), mst_idx: tbl[i].init, tag: 4'(i),
                        snoop: tbl[i].snoop};
                @(posedge clk_i);
                #2;
                if (is_w) begin
                    aw = req;
                    aw_valid = 1'b1;
                end else begin
                    ar = req;
                    ar_valid = 1'b1;
                end
                t = 0;
                do begin
                    @(negedge clk_i);
                    t++;
                end while (!(is_w ? aw_ready : ar_ready) && t < 1000);
                if (t >= 1000) begin
                    errors++;
                    $display("Channel timed out waiting for ready on row %0d", i);
                end
                @(posedge clk_i);
                #2;
                if (is_w) aw_valid = 1'b0;
                else ar_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_dispatches(input int n);
        int t;
        t = 0;
        while (disp_cnt < n && t < 3000) begin
            @(negedge clk_i);
            t++;
        end
        if (disp_cnt < n) begin
            errors++;
            $display("Timed out with %0d of %0d requests dispatched", disp_cnt, n);
        end
    endtask

    initial begin
        int t;
        void'($urandom(32'h20a5_06a1));
        errors = 0;
        disp_cnt = 0;
        hold_gnt = 1'b0;
        aw = '0;
        ar = '0;
        aw_valid = 1'b0;
        ar_valid = 1'b0;
        tbl[0] = '{1'b1, 2'd0, READ_ONCE, 16'h081F, CLEAN_INVALID, 1'b0,
                   SEND_AXI_REQ_WRITE_BACK_W, 1'b1, 1'b0, 2'd0};
        tbl[1] = '{1'b0, 2'd1, READ_SHARED, 16'h59F0, READ_SHARED, 1'b1,
                   SEND_AXI_REQ_R, 1'b1, 1'b1, 2'd2};
        tbl[2] = '{1'b1, 2'd2, READ_ONCE, 16'h0F80, CLEAN_INVALID, 1'b0,
                   SEND_AXI_REQ_W, 1'b1, 1'b0, 2'd0};
        tbl[3] = '{1'b0, 2'd3, READ_UNIQUE, 16'hF023, READ_UNIQUE, 1'b0,
                   SEND_AXI_REQ_R, 1'b0, 1'b0, 2'd0};
        tbl[4] = '{1'b1, 2'd1, READ_SHARED, 16'h30F4, CLEAN_INVALID, 1'b0,
                   SEND_AXI_REQ_W, 1'b0, 1'b1, 2'd0};
        tbl[5] = '{1'b0, 2'd0, READ_ONCE, 16'hD11F, READ_ONCE, 1'b1,
                   SEND_AXI_REQ_R, 1'b1, 1'b1, 2'd1};
        tbl[6] = '{1'b1, 2'd3, READ_UNIQUE, 16'hF500, CLEAN_INVALID, 1'b0,
                   SEND_AXI_REQ_WRITE_BACK_W, 1'b0, 1'b1, 2'd0};
        tbl[7] = '{1'b0, 2'd2, READ_ONCE, 16'h0F00, READ_ONCE, 1'b0,
                   SEND_AXI_REQ_R, 1'b0, 1'b0, 2'd0};
        rst_ni = 1'b0;
        repeat (8) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        @(negedge clk_i);
        check("reset readies", 2'b11, {aw_ready, ar_ready});
        check("reset valids", 0, {ac_valid, cr_ready, su_req, mu_req});

        // Random grant delays
        fork
            drive_channel(1'b1, 0);
            drive_channel(1'b0, 0);
        join
        wait_dispatches(8);

        // Grants held off until the queue and both holders fill
        hold_gnt = 1'b1;
        fork
            drive_channel(1'b1, 1);
            drive_channel(1'b0, 1);
            begin
                t = 0;
                do begin
                    @(negedge clk_i);
                    t++;
                end while ((aw_ready || ar_ready) && t < 500);
                repeat (60) @(negedge clk_i);
                check("backpressure readies", 2'b00, {aw_ready, ar_ready});
                check("held dispatch count", 8, disp_cnt);
                hold_gnt = 1'b0;
            end
        join
        wait_dispatches(16);

        $display("Errors: %0d, dispatches: %0d", errors, disp_cnt);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/ccu_snoop_ctrl_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_defs.svh"

module ccu_snoop_ctrl_asserts import ccu_pkg::*; (
    input wire                    clk_i,
    input wire                    rst_ni,
    input wire                    take_i,
    input axi_req_t               offer_i,
    input snoop_ac_t              ac_o,
    input wire [`CCU_NUM_MST-1:0] ac_valid_o,
    input wire [`CCU_NUM_MST-1:0] ac_ready_i,
    input wire                    su_req_o,
    input wire                    su_gnt_i,
    input wire                    mu_req_o,
    input wire                    mu_gnt_i
);

    // --------------------
    // AC channel
    // --------------------
    for (genvar m = 0; m < `CCU_NUM_MST; m++) begin : g_ac
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            ac_valid_o[m] && !ac_ready_i[m] |=> ac_valid_o[m] && $stable(ac_o))
            else $error("AC valid or payload changed before ready on master %0d", m);

        // The initiator is left out of every broadcast
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            take_i && offer_i.mst_idx == m |=> !ac_valid_o[m])
            else $error("Initiator %0d received its own snoop", m);
    end

    // --------------------
    // Dispatch
    // --------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(su_req_o && mu_req_o))
        else $error("Snoop unit and memory unit requested together");

    assert property (@(posedge clk_i) disable iff (!rst_ni) su_req_o && !su_gnt_i |=> su_req_o)
        else $error("Snoop unit request dropped before grant");

    assert property (@(posedge clk_i) disable iff (!rst_ni) mu_req_o && !mu_gnt_i |=> mu_req_o)
        else $error("Memory unit request dropped before grant");

endmodule

`default_nettype wire

// File: verilog/ccu_snoop_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_defs.svh"

module ccu_snoop_ctrl import ccu_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // Write and read request channels
    input  axi_req_t                    aw_i,
    input  logic                        aw_valid_i,
    output logic                        aw_ready_o,
    input  axi_req_t                    ar_i,
    input  logic                        ar_valid_i,
    output logic                        ar_ready_o,
    // Snoop channels to the masters
    output snoop_ac_t                   ac_o,
    output logic [`CCU_NUM_MST-1:0]     ac_valid_o,
    input  logic [`CCU_NUM_MST-1:0]     ac_ready_i,
    input  logic [`CCU_NUM_MST-1:0]     cr_valid_i,
    output logic [`CCU_NUM_MST-1:0]     cr_ready_o,
    input  cr_resp_t [`CCU_NUM_MST-1:0] cr_resp_i,
    // Snoop unit and memory unit
    output logic                        su_req_o,
    input  logic                        su_gnt_i,
    output logic                        mu_req_o,
    input  logic                        mu_gnt_i,
    output mu_op_e                      mu_op_o,
    output axi_req_t                    pend_o,
    output logic                        shared_o,
    output logic                        dirty_o,
    output logic [`CCU_MST_IDX_W-1:0]   first_responder_o
);

    logic     offer_valid, offer_is_write, take;
    axi_req_t offer;
    logic     push, pop, fifo_full, fifo_empty;
    pend_t    push_data, head;

    req_intake req_intake_i (
        .clk_i, .rst_ni, .aw_i, .aw_valid_i, .aw_ready_o, .ar_i, .ar_valid_i, .ar_ready_o,
        .take_i(take), .offer_valid_o(offer_valid), .offer_o(offer),
        .offer_is_write_o(offer_is_write)
    );

    snoop_issue_fsm snoop_issue_fsm_i (
        .clk_i, .rst_ni, .offer_valid_i(offer_valid), .offer_i(offer),
        .offer_is_write_i(offer_is_write), .fifo_full_i(fifo_full), .ac_ready_i,
        .take_o(take), .push_o(push), .push_data_o(push_data), .ac_o, .ac_valid_o
    );

    pending_fifo pending_fifo_i (
        .clk_i, .rst_ni, .push_i(push), .data_i(push_data), .pop_i(pop),
        .full_o(fifo_full), .empty_o(fifo_empty), .head_o(head)
    );

    resp_collector resp_collector_i (
        .clk_i, .rst_ni, .empty_i(fifo_empty), .head_i(head), .cr_valid_i, .cr_resp_i,
        .su_gnt_i, .mu_gnt_i, .pop_o(pop), .cr_ready_o, .su_req_o, .mu_req_o, .mu_op_o,
        .pend_o, .shared_o, .dirty_o, .first_responder_o
    );

endmodule

`default_nettype wire

// File: verilog/resp_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_defs.svh"

module resp_collector import ccu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      empty_i,
    input  pend_t                     head_i,
    input  logic [`CCU_NUM_MST-1:0]   cr_valid_i,
    input  cr_resp_t [`CCU_NUM_MST-1:0] cr_resp_i,
    input  logic                      su_gnt_i,
    input  logic                      mu_gnt_i,
    output logic                      pop_o,
    output logic [`CCU_NUM_MST-1:0]   cr_ready_o,
    output logic                      su_req_o,
    output logic                      mu_req_o,
    output mu_op_e                    mu_op_o,
    output axi_req_t                  pend_o,
    output logic                      shared_o,
    output logic                      dirty_o,
    output logic [`CCU_MST_IDX_W-1:0] first_responder_o
);

    localparam int unsigned IDX_W = `CCU_MST_IDX_W;

    logic [`CCU_NUM_MST-1:0]     resp_mask_q;
    logic [`CCU_NUM_MST-1:0]     init_oh;
    logic [`CCU_NUM_MST-1:0]     cr_hs;
    cr_resp_t [`CCU_NUM_MST-1:0] resp_q;
    logic                        all_resp;
    logic                        has_data;

    assign init_oh    = {{(`CCU_NUM_MST-1){1'b0}}, 1'b1} << head_i.req.mst_idx;
    assign cr_ready_o = empty_i ? '0 : ~(resp_mask_q | init_oh);
    assign cr_hs      = cr_valid_i & cr_ready_o;
    assign all_resp   = !empty_i && (&(resp_mask_q | init_oh));

    // --------------------
    // CR capture
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_mask_q <= '0;
        end else if (pop_o) begin
            resp_mask_q <= '0;
        end else begin
            resp_mask_q <= resp_mask_q | cr_hs;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `CCU_NUM_MST; i++) begin
            if (cr_hs[i]) begin
                resp_q[i] <= cr_resp_i[i];
            end
        end
    end

    // Walk downwards so the lowest index with data is kept
    always_comb begin
        shared_o          = 1'b0;
        dirty_o           = 1'b0;
        has_data          = 1'b0;
        first_responder_o = '0;
        for (int i = `CCU_NUM_MST - 1; i >= 0; i--) begin
            if (resp_mask_q[i]) begin
                shared_o = shared_o | resp_q[i].is_shared;
                dirty_o  = dirty_o | resp_q[i].pass_dirty;
                if (resp_q[i].data_transfer && !resp_q[i].error) begin
                    has_data          = 1'b1;
                    first_responder_o = IDX_W'(i);
                end
            end
        end
    end

    // --------------------
    // Dispatch
    // --------------------
    assign su_req_o = all_resp && !head_i.is_write && has_data;
    assign mu_req_o = all_resp && (head_i.is_write || !has_data);
    assign pop_o    = (su_req_o && su_gnt_i) || (mu_req_o && mu_gnt_i);
    assign pend_o   = head_i.req;

    always_comb begin
        if (!head_i.is_write) begin
            mu_op_o = SEND_AXI_REQ_R;
        end else if (has_data) begin
            mu_op_o = SEND_AXI_REQ_WRITE_BACK_W;
        end else begin
            mu_op_o = SEND_AXI_REQ_W;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pending_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_defs.svh"

module pending_fifo import ccu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  push_i,
    input  pend_t data_i,
    input  logic  pop_i,
    output logic  full_o,
    output logic  empty_o,
    output pend_t head_o
);

    localparam int unsigned PTR_W = $clog2(`CCU_FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(`CCU_FIFO_DEPTH + 1);

    pend_t            mem_q [`CCU_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             do_push, do_pop;

    assign full_o  = (cnt_q == CNT_W'(`CCU_FIFO_DEPTH));
    assign empty_o = (cnt_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`CCU_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`CCU_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/snoop_issue_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ccu_defs.svh"

module snoop_issue_fsm import ccu_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    offer_valid_i,
    input  axi_req_t                offer_i,
    input  logic                    offer_is_write_i,
    input  logic                    fifo_full_i,
    input  logic [`CCU_NUM_MST-1:0] ac_ready_i,
    output logic                    take_o,
    output logic                    push_o,
    output pend_t                   push_data_o,
    output snoop_ac_t               ac_o,
    output logic [`CCU_NUM_MST-1:0] ac_valid_o
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e                  state_q, state_d;
    // Masters done with the current AC, initiator included
    logic [`CCU_NUM_MST-1:0] done_q, done_d;
    logic [`CCU_NUM_MST-1:0] ac_hs;
    logic [`CCU_NUM_MST-1:0] init_oh;
    snoop_ac_t               ac_q;
    snoop_ac_t               ac_new;

    assign init_oh    = {{(`CCU_NUM_MST-1){1'b0}}, 1'b1} << offer_i.mst_idx;
    assign ac_valid_o = (state_q == BUSY) ? ~done_q : '0;
    assign ac_hs      = ac_valid_o & ac_ready_i;
    assign ac_o       = ac_q;

    // Writes invalidate every other copy
    always_comb begin
        ac_new.addr  = offer_i.addr;
        ac_new.snoop = offer_is_write_i ? CLEAN_INVALID : offer_i.snoop;
    end

    assign push_o               = take_o;
    assign push_data_o.req      = offer_i;
    assign push_data_o.is_write = offer_is_write_i;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        done_d  = done_q;
        take_o  = 1'b0;
        case (state_q)
            IDLE: begin
                if (offer_valid_i && !fifo_full_i) begin
                    take_o  = 1'b1;
                    done_d  = init_oh;
                    state_d = BUSY;
                end
            end
            BUSY: begin
                done_d = done_q | ac_hs;
                if (&done_d) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            done_q  <= '0;
        end else begin
            state_q <= state_d;
            done_q  <= done_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            ac_q <= ac_new;
        end
    end

endmodule

`default_nettype wire

// File: verilog/req_intake.sv
`timescale 1ns/1ps
`default_nettype none

module req_intake import ccu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  axi_req_t aw_i,
    input  logic     aw_valid_i,
    output logic     aw_ready_o,
    input  axi_req_t ar_i,
    input  logic     ar_valid_i,
    output logic     ar_ready_o,
    input  logic     take_i,
    output logic     offer_valid_o,
    output axi_req_t offer_o,
    output logic     offer_is_write_o
);

    axi_req_t aw_q;
    axi_req_t ar_q;
    logic     aw_valid_q;
    logic     ar_valid_q;
    // Write side wins a tie while set
    logic     prio_w_q;

    assign aw_ready_o = !aw_valid_q;
    assign ar_ready_o = !ar_valid_q;

    // --------------------
    // Channel holders
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aw_valid_q <= 1'b0;
            ar_valid_q <= 1'b0;
        end else begin
            if (aw_valid_i && aw_ready_o) begin
                aw_valid_q <= 1'b1;
            end else if (take_i && offer_is_write_o) begin
                aw_valid_q <= 1'b0;
            end
            if (ar_valid_i && ar_ready_o) begin
                ar_valid_q <= 1'b1;
            end else if (take_i && !offer_is_write_o) begin
                ar_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_valid_i && aw_ready_o) begin
            aw_q <= aw_i;
        end
        if (ar_valid_i && ar_ready_o) begin
            ar_q <= ar_i;
        end
    end

    // --------------------
    // Round robin
    // --------------------
    assign offer_valid_o    = aw_valid_q || ar_valid_q;
    assign offer_is_write_o = aw_valid_q && (!ar_valid_q || prio_w_q);
    assign offer_o          = offer_is_write_o ? aw_q : ar_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_w_q <= 1'b1;
        end else if (take_i) begin
            prio_w_q <= !offer_is_write_o;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ccu_pkg.sv
`default_nettype none

`include "ccu_defs.svh"

package ccu_pkg;

    // ACE snoop codes
    typedef enum logic [3:0] {
        READ_ONCE     = 4'b0000,
        READ_SHARED   = 4'b0001,
        READ_UNIQUE   = 4'b0111,
        CLEAN_INVALID = 4'b1001
    } snoop_e;

    typedef struct packed {
        logic [`CCU_ADDR_W-1:0]    addr;
        logic [`CCU_MST_IDX_W-1:0] mst_idx;
        logic [`CCU_TAG_W-1:0]     tag;
        snoop_e                    snoop;
    } axi_req_t;

    typedef struct packed {
        logic [`CCU_ADDR_W-1:0] addr;
        snoop_e                 snoop;
    } snoop_ac_t;

    // Same bit order as CRRESP[3:0]
    typedef struct packed {
        logic is_shared;
        logic pass_dirty;
        logic error;
        logic data_transfer;
    } cr_resp_t;

    typedef struct packed {
        axi_req_t req;
        logic     is_write;
    } pend_t;

    typedef enum logic [1:0] {
        SEND_AXI_REQ_R,
        SEND_AXI_REQ_W,
        SEND_AXI_REQ_WRITE_BACK_W
    } mu_op_e;

endpackage

`default_nettype wire

// File: verilog/ccu_defs.svh
`ifndef CCU_DEFS_SVH
`define CCU_DEFS_SVH

// Cached masters on the interconnect
`define CCU_NUM_MST    4
`define CCU_MST_IDX_W  2

`define CCU_ADDR_W     32

// Transaction tag below the master index
`define CCU_TAG_W      4

// Requests that were snooped and wait for CR
`define CCU_FIFO_DEPTH 4

`endif
